//--- hw/frv_wb_pkg.sv
// Writeback stage common definitions
package frv_wb_pkg;

    localparam int xlen = 32;

    localparam logic [xlen-1:0] pc_reset_value = 32'h8000_0000;

    // Functional unit one-hot bit positions
    localparam int fu_alu = 0;
    localparam int fu_mul = 1;
    localparam int fu_lsu = 2;
    localparam int fu_cfu = 3;
    localparam int fu_csr = 4;

    // Control flow micro-ops
    localparam logic [4:0] cfu_taken  = 5'b00111;
    localparam logic [4:0] cfu_jali   = 5'b01000;
    localparam logic [4:0] cfu_jalr   = 5'b01001;
    localparam logic [4:0] cfu_ebreak = 5'b11001;
    localparam logic [4:0] cfu_ecall  = 5'b11010;
    localparam logic [4:0] cfu_mret   = 5'b11100;

    localparam logic [1:0] lsu_byte = 2'b01;
    localparam logic [1:0] lsu_half = 2'b10;
    localparam logic [1:0] lsu_word = 2'b11;

    localparam logic [11:0] csr_addr_mtvec    = 12'h305;
    localparam logic [11:0] csr_addr_mscratch = 12'h340;
    localparam logic [11:0] csr_addr_mepc     = 12'h341;
    localparam logic [11:0] csr_addr_mcause   = 12'h342;

    // Exception causes
    localparam logic [5:0] trap_breakpt  = 6'd3;
    localparam logic [5:0] trap_ldaccess = 6'd5;
    localparam logic [5:0] trap_staccess = 6'd7;
    localparam logic [5:0] trap_ecallm   = 6'd11;

    // Micro-op word, meaning depends on the owning functional unit
    typedef union packed {
        struct packed {
            logic read;
            logic write;
            logic set;
            logic clear;
            logic rsvd;
        } csr;
        struct packed {
            logic       store;
            logic       load;
            logic [1:0] size;
            logic       is_signed;
        } lsu;
        logic [4:0] cfu;             // Whole code compared against cfu_*
    } wb_uop_t;

endpackage

//--- hw/frv_load_align.sv
// Load data alignment
`timescale 1ns/1ns

module frv_load_align (
    input  logic [frv_wb_pkg::xlen-1:0] mem_rdata,   // Raw word from data memory
    input  logic [1:0]                  byte_addr,
    input  logic [1:0]                  size,
    input  logic                        is_signed,
    output logic [frv_wb_pkg::xlen-1:0] load_data
);
    import frv_wb_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // Byte lane picked by the low address bits
    assign lane_b = mem_rdata[{byte_addr, 3'b000} +: 8];

    // Halfword lane, bit 0 of the address is ignored
    assign lane_h = byte_addr[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (size)
            lsu_byte: load_data = {{(xlen-8){is_signed & lane_b[7]}}, lane_b};
            lsu_half: load_data = {{(xlen-16){is_signed & lane_h[15]}}, lane_h};
            lsu_word: load_data = mem_rdata;
            default:  load_data = mem_rdata;
        endcase
    end

endmodule

//--- hw/frv_gpr_file.sv
// General purpose register file
`timescale 1ns/1ns

module frv_gpr_file (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        wen,
    input  logic [4:0]                  waddr,
    input  logic [frv_wb_pkg::xlen-1:0] wdata,
    input  logic [4:0]                  rs1_addr,
    input  logic [4:0]                  rs2_addr,
    output logic [frv_wb_pkg::xlen-1:0] rs1_rdata,
    output logic [frv_wb_pkg::xlen-1:0] rs2_rdata
);
    import frv_wb_pkg::*;

    logic [xlen-1:0] regs [1:31];    // No storage behind x0

    always_ff @(posedge g_clk) begin
        if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rs1_rdata = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_rdata = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

    // Writeback never commits an unresolved result
    a_wdata_known: assert property (@(posedge g_clk) disable iff (!g_resetn)
        wen |-> !$isunknown(wdata));

endmodule

//--- hw/frv_csr_regs.sv
// Machine mode CSR block
`timescale 1ns/1ns

module frv_csr_regs (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        csr_en,      // One cycle per CSR instruction
    input  logic                        csr_wr,
    input  logic                        csr_wr_set,
    input  logic                        csr_wr_clr,
    input  logic [11:0]                 csr_addr,
    input  logic [frv_wb_pkg::xlen-1:0] csr_wdata,
    input  logic                        trap_take,
    input  logic                        trap_int,
    input  logic [5:0]                  trap_cause,
    input  logic [frv_wb_pkg::xlen-1:0] trap_pc,
    input  logic                        exec_mret,
    output logic [frv_wb_pkg::xlen-1:0] csr_rdata,
    output logic [frv_wb_pkg::xlen-1:0] csr_mepc,
    output logic [frv_wb_pkg::xlen-1:0] csr_mtvec
);
    import frv_wb_pkg::*;

    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] wr_value;
    logic            wr_any;

    // Read mux, holes read zero
    always_comb begin
        case (csr_addr)
            csr_addr_mtvec:    csr_rdata = mtvec;
            csr_addr_mepc:     csr_rdata = mepc;
            csr_addr_mcause:   csr_rdata = mcause;
            csr_addr_mscratch: csr_rdata = mscratch;
            default:           csr_rdata = '0;
        endcase
    end

    assign wr_any   = csr_en && (csr_wr || csr_wr_set || csr_wr_clr);
    assign wr_value = csr_wr     ? csr_wdata :
                      csr_wr_set ? (csr_rdata | csr_wdata) :
                                   (csr_rdata & ~csr_wdata);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= '0;
        end else if (trap_take) begin
            mepc   <= trap_pc;
            mcause <= {trap_int, {(xlen-7){1'b0}}, trap_cause};  // Bit 31 marks interrupts
        end else if (wr_any) begin
            case (csr_addr)
                csr_addr_mtvec:    mtvec    <= wr_value;
                csr_addr_mepc:     mepc     <= wr_value;
                csr_addr_mcause:   mcause   <= wr_value;
                csr_addr_mscratch: mscratch <= wr_value;
                default: ;
            endcase
        end
    end

    assign csr_mepc  = mepc;
    assign csr_mtvec = mtvec;

    // A redirect to the trap vector retires nothing else
    a_no_wr_on_trap: assert property (@(posedge g_clk) disable iff (!g_resetn)
        trap_take |-> !(wr_any || exec_mret));

endmodule

//--- hw/frv_pipeline_writeback.sv
// RISC-V pipeline writeback stage
`timescale 1ns/1ns

module frv_pipeline_writeback (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        s4_valid,
    input  logic [4:0]                  s4_rd,
    input  logic [frv_wb_pkg::xlen-1:0] s4_opr_a,       // Result or jump target
    input  logic [frv_wb_pkg::xlen-1:0] s4_opr_b,       // CSR address or memory address
    input  frv_wb_pkg::wb_uop_t         s4_uop,
    input  logic [4:0]                  s4_fu,
    input  logic                        s4_trap,
    input  logic [1:0]                  s4_size,        // Length in halfwords
    input  logic [31:0]                 s4_instr,
    output logic                        s4_busy,
    output logic                        cf_req,
    output logic [frv_wb_pkg::xlen-1:0] cf_target,
    input  logic                        cf_ack,
    input  logic                        dmem_recv,
    input  logic                        dmem_error,
    output logic                        dmem_ack,
    output logic                        hold_lsu_req,
    input  logic [frv_wb_pkg::xlen-1:0] load_data,
    input  logic                        int_trap_req,
    input  logic [5:0]                  int_trap_cause,
    output logic                        int_trap_ack,
    output logic                        gpr_wen,
    output logic [4:0]                  gpr_rd,
    output logic [frv_wb_pkg::xlen-1:0] gpr_wdata,
    output logic [4:0]                  fwd_rd,
    output logic [frv_wb_pkg::xlen-1:0] fwd_wdata,
    output logic                        fwd_load,
    output logic                        fwd_csr,
    output logic                        csr_en,
    output logic                        csr_wr,
    output logic                        csr_wr_set,
    output logic                        csr_wr_clr,
    output logic [11:0]                 csr_addr,
    output logic [frv_wb_pkg::xlen-1:0] csr_wdata,
    input  logic [frv_wb_pkg::xlen-1:0] csr_rdata,
    input  logic [frv_wb_pkg::xlen-1:0] csr_mepc,
    input  logic [frv_wb_pkg::xlen-1:0] csr_mtvec,
    output logic                        trap_cpu,
    output logic                        trap_int,
    output logic                        trap_take,
    output logic [5:0]                  trap_cause,
    output logic [frv_wb_pkg::xlen-1:0] trap_pc,
    output logic                        exec_mret,
    output logic [frv_wb_pkg::xlen-1:0] trs_pc,
    output logic [31:0]                 trs_instr,
    output logic                        trs_valid
);
    import frv_wb_pkg::*;

    logic            retire;
    logic [xlen-1:0] s4_pc;
    logic [xlen-1:0] pc_next;
    logic            is_alu;
    logic            is_mul;
    logic            is_lsu;
    logic            is_cfu;
    logic            is_csr;
    logic            op_jump;
    logic            op_link;
    logic            op_ebreak;
    logic            op_ecall;
    logic            op_mret;
    logic            lsu_load;
    logic            lsu_store;
    logic            lsu_busy;
    logic            lsu_err;
    logic            trap_any;
    logic            csr_done;
    logic            cfu_done;
    logic            rsp_seen;
    logic            err_seen;

    // ---------------------------------------------------------------------------
    // Decode and progress

    assign is_alu = s4_valid && s4_fu[fu_alu];
    assign is_mul = s4_valid && s4_fu[fu_mul];
    assign is_lsu = s4_valid && s4_fu[fu_lsu];
    assign is_cfu = s4_valid && s4_fu[fu_cfu];
    assign is_csr = s4_valid && s4_fu[fu_csr];

    assign retire  = s4_valid && !s4_busy;
    assign s4_busy = (cf_req && !cf_ack) || lsu_busy;

    assign pc_next = s4_pc + {{(xlen-3){1'b0}}, s4_size, 1'b0};

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_pc <= pc_reset_value;
        end else if (cf_req && cf_ack) begin
            s4_pc <= cf_target;
        end else if (retire && !cfu_done) begin   // Already redirected otherwise
            s4_pc <= pc_next;
        end
    end

    // ---------------------------------------------------------------------------
    // Load/store response and control flow

    assign lsu_load     = is_lsu && s4_uop.lsu.load;
    assign lsu_store    = is_lsu && s4_uop.lsu.store;
    assign dmem_ack     = is_lsu && !s4_trap && !rsp_seen;
    assign lsu_busy     = dmem_ack && !dmem_recv;
    assign lsu_err      = (dmem_ack && dmem_recv && dmem_error) || err_seen;
    assign hold_lsu_req = cf_req || lsu_busy;

    assign op_jump   = is_cfu && (s4_uop.cfu == cfu_taken || s4_uop.cfu == cfu_jali ||
                                  s4_uop.cfu == cfu_jalr);
    assign op_link   = is_cfu && (s4_uop.cfu == cfu_jali || s4_uop.cfu == cfu_jalr);
    assign op_ebreak = is_cfu && s4_uop.cfu == cfu_ebreak;
    assign op_ecall  = is_cfu && s4_uop.cfu == cfu_ecall;
    assign op_mret   = is_cfu && s4_uop.cfu == cfu_mret;

    assign trap_cpu = op_ebreak || op_ecall || lsu_err || (s4_valid && s4_trap);
    assign trap_int = s4_valid && int_trap_req && !trap_cpu;    // CPU traps win
    assign trap_any = trap_cpu || trap_int;

    assign cf_req    = !cfu_done && (op_jump || op_mret || trap_any);
    assign cf_target = trap_any ? csr_mtvec : (op_mret ? csr_mepc : s4_opr_a);

    assign trap_take    = trap_any && cf_req && cf_ack;
    assign int_trap_ack = trap_int && cf_req && cf_ack;
    assign exec_mret    = op_mret && retire && !trap_any;

    assign trap_cause = (lsu_err && lsu_load)  ? trap_ldaccess :
                        (lsu_err && lsu_store) ? trap_staccess :
                        op_ebreak              ? trap_breakpt  :
                        op_ecall               ? trap_ecallm   :
                        trap_int               ? int_trap_cause :
                                                 s4_opr_a[5:0];
    assign trap_pc    = s4_pc;

    // Side effect flags, cleared as the instruction leaves
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            csr_done <= 1'b0;
            cfu_done <= 1'b0;
            rsp_seen <= 1'b0;
            err_seen <= 1'b0;
        end else if (retire) begin
            csr_done <= 1'b0;
            cfu_done <= 1'b0;
            rsp_seen <= 1'b0;
            err_seen <= 1'b0;
        end else begin
            csr_done <= csr_done || csr_en;
            cfu_done <= cfu_done || (cf_req && cf_ack);
            rsp_seen <= rsp_seen || (dmem_ack && dmem_recv);
            err_seen <= lsu_err;           // Holds the trap until cf_ack
        end
    end

    // ---------------------------------------------------------------------------
    // CSR access, GPR writeback and forwarding

    assign csr_en     = is_csr && !csr_done && !trap_any;
    assign csr_wr     = is_csr && s4_uop.csr.write;
    assign csr_wr_set = is_csr && s4_uop.csr.set;
    assign csr_wr_clr = is_csr && s4_uop.csr.clear;
    assign csr_addr   = s4_opr_b[11:0];
    assign csr_wdata  = s4_opr_a;

    assign gpr_rd  = s4_rd;
    assign gpr_wen = retire && !trap_any &&
                     (is_alu || is_mul || op_link || lsu_load || (csr_en && s4_uop.csr.read));

    always_comb begin
        if (is_csr) begin
            gpr_wdata = csr_rdata;           // Value before this write lands
        end else if (is_lsu) begin
            gpr_wdata = load_data;
        end else if (op_link) begin
            gpr_wdata = pc_next;
        end else begin
            gpr_wdata = s4_opr_a;
        end
    end

    assign fwd_rd    = s4_rd;
    assign fwd_wdata = gpr_wdata;
    assign fwd_load  = lsu_load;
    assign fwd_csr   = is_csr;

    assign trs_pc    = s4_pc;
    assign trs_instr = s4_instr;
    assign trs_valid = retire;

    // Fetch relies on a steady redirect until it acknowledges
    a_cf_target_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (cf_req && !cf_ack) |=> (cf_req && $stable(cf_target)));

    a_fu_onehot: assert property (@(posedge g_clk) disable iff (!g_resetn)
        s4_valid |-> $onehot0(s4_fu));

endmodule

//--- hw/frv_wb_top.sv
// Writeback stage top level
`timescale 1ns/1ns

module frv_wb_top (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        s4_valid,
    input  logic [4:0]                  s4_rd,
    input  logic [frv_wb_pkg::xlen-1:0] s4_opr_a,
    input  logic [frv_wb_pkg::xlen-1:0] s4_opr_b,
    input  frv_wb_pkg::wb_uop_t         s4_uop,
    input  logic [4:0]                  s4_fu,
    input  logic                        s4_trap,
    input  logic [1:0]                  s4_size,
    input  logic [31:0]                 s4_instr,
    output logic                        s4_busy,
    output logic                        cf_req,
    output logic [frv_wb_pkg::xlen-1:0] cf_target,
    input  logic                        cf_ack,
    input  logic                        dmem_recv,
    input  logic                        dmem_error,
    input  logic [frv_wb_pkg::xlen-1:0] dmem_rdata,
    output logic                        dmem_ack,
    output logic                        hold_lsu_req,
    input  logic                        int_trap_req,
    input  logic [5:0]                  int_trap_cause,
    output logic                        int_trap_ack,
    output logic [4:0]                  fwd_rd,
    output logic [frv_wb_pkg::xlen-1:0] fwd_wdata,
    output logic                        fwd_load,
    output logic                        fwd_csr,
    output logic                        trap_cpu,
    output logic                        trap_int,
    output logic [5:0]                  trap_cause,
    output logic [frv_wb_pkg::xlen-1:0] trap_pc,
    output logic                        exec_mret,
    output logic [frv_wb_pkg::xlen-1:0] trs_pc,
    output logic [31:0]                 trs_instr,
    output logic                        trs_valid,
    input  logic [4:0]                  rs1_addr,    // Decode side read ports
    input  logic [4:0]                  rs2_addr,
    output logic [frv_wb_pkg::xlen-1:0] rs1_rdata,
    output logic [frv_wb_pkg::xlen-1:0] rs2_rdata
);
    import frv_wb_pkg::*;

    logic [xlen-1:0] load_data;
    logic            gpr_wen;
    logic [4:0]      gpr_rd;
    logic [xlen-1:0] gpr_wdata;
    logic            csr_en;
    logic            csr_wr;
    logic            csr_wr_set;
    logic            csr_wr_clr;
    logic [11:0]     csr_addr;
    logic [xlen-1:0] csr_wdata;
    logic [xlen-1:0] csr_rdata;
    logic [xlen-1:0] csr_mepc;
    logic [xlen-1:0] csr_mtvec;
    logic            trap_take;

    frv_pipeline_writeback u_wb (.*);

    frv_csr_regs u_csr (.*);

    frv_gpr_file u_gpr (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .wen       (gpr_wen),
        .waddr     (gpr_rd),
        .wdata     (gpr_wdata),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_rdata (rs1_rdata),
        .rs2_rdata (rs2_rdata)
    );

    // Address low bits come from operand B
    frv_load_align u_align (
        .mem_rdata (dmem_rdata),
        .byte_addr (s4_opr_b[1:0]),
        .size      (s4_uop.lsu.size),
        .is_signed (s4_uop.lsu.is_signed),
        .load_data (load_data)
    );

endmodule

//--- tests/tb_frv_wb_top.sv
// Writeback stage testbench
`timescale 1ns/1ns

module tb_frv_wb_top;
    import frv_wb_pkg::*;

    typedef struct {
        logic [4:0]  fu;
        wb_uop_t     uop;
        logic [4:0]  rd;
        logic [31:0] opr_a;
        logic [31:0] opr_b;
        logic [1:0]  size;
        logic [31:0] instr;
        logic [2:0]  flags;          // Bit 0 bus error, bit 1 irq, bit 2 ack expected
        logic [31:0] exp_gpr;
        logic [31:0] exp_tgt;        // Zero when no redirect
        logic [7:0]  exp_cause;      // FF when no trap
    } entry_t;

    logic g_clk, g_resetn, s4_valid, s4_trap, cf_ack, dmem_recv, dmem_error, int_trap_req;
    logic [4:0] s4_rd, s4_fu, rs1_addr, rs2_addr, fwd_rd;
    logic [31:0] s4_opr_a, s4_opr_b, s4_instr, dmem_rdata;
    wb_uop_t s4_uop;
    logic [1:0] s4_size;
    logic [5:0] int_trap_cause, trap_cause;
    logic s4_busy, cf_req, dmem_ack, hold_lsu_req, int_trap_ack, fwd_load, fwd_csr;
    logic trap_cpu, trap_int, exec_mret, trs_valid;
    logic [31:0] cf_target, fwd_wdata, trap_pc, trs_pc, trs_instr, rs1_rdata, rs2_rdata;

    entry_t      tbl[$];
    logic [15:0] lfsr;
    logic [31:0] tb_pc;
    int          errors;
    bit          timed_out;

    frv_wb_top dut0 (.*);

    initial g_clk = 1'b0;
    always #50 g_clk = ~g_clk;

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic int rand_delay();
        int d;
        d = 0;
        repeat (2) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            d = d * 2 + int'(lfsr[0]);
        end
        return d;
    endfunction

    task automatic add(input logic [4:0] fu, input logic [4:0] uop, input logic [4:0] rd,
                       input logic [31:0] a, input logic [31:0] b, input logic [2:0] flg,
                       input logic [31:0] gpr, input logic [31:0] tgt, input logic [7:0] cause);
        entry_t e;
        e.fu = fu;
        e.uop = uop;
        e.rd = rd;
        e.opr_a = a;
        e.opr_b = b;
        e.size = 2'd2;
        e.instr = 32'h0000_0013 + 32'(tbl.size()) * 32'h80;
        e.flags = flg;
        e.exp_gpr = gpr;
        e.exp_tgt = tgt;
        e.exp_cause = cause;
        tbl.push_back(e);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input int idx);
        if (got !== exp) begin
            $display("FAILED entry %0d %s: got %h expected %h", idx, name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // One instruction, with randomly delayed cf_ack and dmem_recv
    task automatic run_entry(input int idx);
        entry_t e;
        int     cyc;
        int     ack_dly;
        int     rsp_dly;
        bit     done;
        bit     is_mret;
        bit     mem_wait;
        bit     cf_wait;
        bit     exp_ret;
        e = tbl[idx];
        is_mret = e.fu[fu_cfu] && e.uop.cfu == cfu_mret;
        s4_valid = 1'b1;
        s4_fu = e.fu;
        s4_uop = e.uop;
        s4_rd = e.rd;
        s4_opr_a = e.opr_a;
        s4_opr_b = e.opr_b;
        s4_size = e.size;
        s4_instr = e.instr;
        int_trap_req = e.flags[1];
        ack_dly = -1;
        rsp_dly = -1;
        done = 0;
        cyc = 0;
        while (!done && cyc < 50) begin
            @(negedge g_clk);
            mem_wait = e.fu[fu_lsu] && rsp_dly != -2;    // Response not yet given
            cf_wait  = e.exp_tgt != 32'h0 && !mem_wait;
            exp_ret  = !mem_wait && (e.exp_tgt == 32'h0 || cf_ack);
            check_value("s4_busy", 32'(s4_busy), 32'(!exp_ret), idx);
            check_value("trs_valid", 32'(trs_valid), 32'(exp_ret), idx);
            check_value("cf_req", 32'(cf_req), 32'(cf_wait), idx);
            check_value("hold_lsu_req", 32'(hold_lsu_req), 32'(mem_wait || cf_wait), idx);
            check_value("dmem_ack", 32'(dmem_ack),
                        32'(mem_wait || (e.fu[fu_lsu] && dmem_recv)), idx);
            check_value("int_trap_ack", 32'(int_trap_ack), 32'(e.flags[2] && exp_ret), idx);
            check_value("exec_mret", 32'(exec_mret), 32'(is_mret && exp_ret), idx);
            if (cf_req) check_value("cf_target", cf_target, e.exp_tgt, idx);
            if (trs_valid) begin
                done = 1;
                check_value("trs_pc", trs_pc, tb_pc, idx);
                check_value("trap_pc", trap_pc, tb_pc, idx);
                check_value("trs_instr", trs_instr, e.instr, idx);
                check_value("trap_cpu", 32'(trap_cpu),
                            32'(e.exp_cause != 8'hFF && !e.flags[2]), idx);
                check_value("trap_int", 32'(trap_int), 32'(e.flags[2]), idx);
                if (e.exp_cause != 8'hFF) check_value("trap_cause", 32'(trap_cause),
                                                      32'(e.exp_cause), idx);
                check_value("fwd_rd", 32'(fwd_rd), 32'(e.rd), idx);
                check_value("fwd_load", 32'(fwd_load), 32'(e.fu[fu_lsu] && e.uop.lsu.load), idx);
                check_value("fwd_csr", 32'(fwd_csr), 32'(e.fu[fu_csr]), idx);
                if ((e.fu[fu_alu] || e.fu[fu_mul]) && e.rd != 5'd0 && e.exp_cause == 8'hFF)
                    check_value("fwd_wdata", fwd_wdata, e.exp_gpr, idx);
                tb_pc = (e.exp_tgt != 32'h0) ? e.exp_tgt : tb_pc + {29'd0, e.size, 1'b0};
            end else begin
                if (cf_req && ack_dly == -1) ack_dly = rand_delay();
                if (dmem_ack && rsp_dly == -1) rsp_dly = rand_delay();
            end
            @(posedge g_clk);
            #1;
            cf_ack = 1'b0;
            dmem_recv = 1'b0;
            dmem_error = 1'b0;
            if (!done) begin
                if (ack_dly == 0) begin
                    cf_ack = 1'b1;
                    ack_dly = -2;
                end else if (ack_dly > 0) begin
                    ack_dly--;
                end
                if (rsp_dly == 0) begin
                    dmem_recv = 1'b1;
                    dmem_error = e.flags[0];
                    rsp_dly = -2;
                end else if (rsp_dly > 0) begin
                    rsp_dly--;
                end
            end
            cyc++;
        end
        if (!done) begin
            $display("Timeout: entry %0d never retired", idx);
            timed_out = 1;
        end
        // Idle cycle, GPR readback and quiet outputs
        s4_valid = 1'b0;
        int_trap_req = 1'b0;
        rs1_addr = e.rd;
        rs2_addr = e.rd;
        @(negedge g_clk);
        check_value("gpr", rs1_rdata, e.exp_gpr, idx);
        check_value("gpr port 2", rs2_rdata, e.exp_gpr, idx);
        check_value("dmem_ack", 32'(dmem_ack), 32'h0, idx);
        check_value("cf_req", 32'(cf_req), 32'h0, idx);
        check_value("trs_valid", 32'(trs_valid), 32'h0, idx);
        @(posedge g_clk);
        #1;
    endtask

    initial begin
        errors = 0;
        timed_out = 0;
        lfsr = 16'd9595;
        tb_pc = pc_reset_value;
        g_resetn = 1'b0;
        s4_valid = 1'b0;
        s4_rd = '0;
        s4_opr_a = '0;
        s4_opr_b = '0;
        s4_uop = '0;
        s4_fu = '0;
        s4_trap = 1'b0;
        s4_size = 2'd2;
        s4_instr = '0;
        cf_ack = 1'b0;
        dmem_recv = 1'b0;
        dmem_error = 1'b0;
        dmem_rdata = 32'h8F70_A5C3;
        int_trap_req = 1'b0;
        int_trap_cause = 6'h10;
        rs1_addr = '0;
        rs2_addr = '0;

        // ALU, MUL, x0, then CSR sequence
        add(5'b00001, 5'b00000, 5'd1, 32'h1234_5678, 32'h0, 3'b000, 32'h1234_5678, 32'h0, 8'hFF);
        add(5'b00010, 5'b00000, 5'd2, 32'hDEAD_BEEF, 32'h0, 3'b000, 32'hDEAD_BEEF, 32'h0, 8'hFF);
        add(5'b00001, 5'b00000, 5'd0, 32'hFFFF_FFFF, 32'h0, 3'b000, 32'h0, 32'h0, 8'hFF);
        add(5'b10000, 5'b11000, 5'd3, 32'h8000_0100, 32'h305, 3'b000, 32'h0, 32'h0, 8'hFF);
        add(5'b10000, 5'b11000, 5'd4, 32'h0000_00F0, 32'h340, 3'b000, 32'h0, 32'h0, 8'hFF);
        add(5'b10000, 5'b10100, 5'd4, 32'h0000_0F00, 32'h340, 3'b000, 32'hF0, 32'h0, 8'hFF);
        add(5'b10000, 5'b10010, 5'd4, 32'h0000_00F0, 32'h340, 3'b000, 32'hFF0, 32'h0, 8'hFF);
        add(5'b10000, 5'b10000, 5'd5, 32'h0, 32'h340, 3'b000, 32'hF00, 32'h0, 8'hFF);
        add(5'b10000, 5'b10000, 5'd6, 32'h0, 32'h305, 3'b000, 32'h8000_0100, 32'h0, 8'hFF);
        // Loads from memory word 8F70A5C3
        add(5'b00100, 5'b01011, 5'd7, 32'h0, 32'h2000_0000, 3'b000, 32'hFFFF_FFC3, 32'h0, 8'hFF);
        add(5'b00100, 5'b01011, 5'd7, 32'h0, 32'h2000_0001, 3'b000, 32'hFFFF_FFA5, 32'h0, 8'hFF);
        add(5'b00100, 5'b01011, 5'd7, 32'h0, 32'h2000_0002, 3'b000, 32'h0000_0070, 32'h0, 8'hFF);
        add(5'b00100, 5'b01011, 5'd7, 32'h0, 32'h2000_0003, 3'b000, 32'hFFFF_FF8F, 32'h0, 8'hFF);
        add(5'b00100, 5'b01010, 5'd7, 32'h0, 32'h2000_0000, 3'b000, 32'h0000_00C3, 32'h0, 8'hFF);
        add(5'b00100, 5'b01010, 5'd7, 32'h0, 32'h2000_0001, 3'b000, 32'h0000_00A5, 32'h0, 8'hFF);
        add(5'b00100, 5'b01010, 5'd7, 32'h0, 32'h2000_0002, 3'b000, 32'h0000_0070, 32'h0, 8'hFF);
        add(5'b00100, 5'b01010, 5'd7, 32'h0, 32'h2000_0003, 3'b000, 32'h0000_008F, 32'h0, 8'hFF);
        add(5'b00100, 5'b01101, 5'd7, 32'h0, 32'h2000_0000, 3'b000, 32'hFFFF_A5C3, 32'h0, 8'hFF);
        add(5'b00100, 5'b01101, 5'd7, 32'h0, 32'h2000_0002, 3'b000, 32'hFFFF_8F70, 32'h0, 8'hFF);
        add(5'b00100, 5'b01100, 5'd7, 32'h0, 32'h2000_0000, 3'b000, 32'h0000_A5C3, 32'h0, 8'hFF);
        add(5'b00100, 5'b01100, 5'd7, 32'h0, 32'h2000_0002, 3'b000, 32'h0000_8F70, 32'h0, 8'hFF);
        add(5'b00100, 5'b01110, 5'd7, 32'h0, 32'h2000_0000, 3'b000, 32'h8F70_A5C3, 32'h0, 8'hFF);
        add(5'b00100, 5'b10110, 5'd1, 32'h0, 32'h2000_0010, 3'b000, 32'h1234_5678, 32'h0, 8'hFF);
        // Jumps and links
        add(5'b01000, cfu_jali, 5'd8, 32'h8000_0200, 32'h0, 3'b000, 32'h8000_0060,
            32'h8000_0200, 8'hFF);
        add(5'b01000, cfu_taken, 5'd0, 32'h8000_0300, 32'h0, 3'b000, 32'h0, 32'h8000_0300, 8'hFF);
        add(5'b01000, cfu_jalr, 5'd9, 32'h8000_0400, 32'h0, 3'b000, 32'h8000_0304,
            32'h8000_0400, 8'hFF);
        // Traps and returns
        add(5'b01000, cfu_ecall, 5'd1, 32'h0, 32'h0, 3'b000, 32'h1234_5678, 32'h8000_0100, 8'h0B);
        add(5'b01000, cfu_mret, 5'd0, 32'h0, 32'h0, 3'b000, 32'h0, 32'h8000_0400, 8'hFF);
        add(5'b01000, cfu_ebreak, 5'd1, 32'h0, 32'h0, 3'b000, 32'h1234_5678, 32'h8000_0100, 8'h03);
        add(5'b01000, cfu_mret, 5'd0, 32'h0, 32'h0, 3'b000, 32'h0, 32'h8000_0400, 8'hFF);
        add(5'b00100, 5'b01110, 5'd1, 32'h0, 32'h2000_0000, 3'b001, 32'h1234_5678,
            32'h8000_0100, 8'h05);
        add(5'b01000, cfu_mret, 5'd0, 32'h0, 32'h0, 3'b000, 32'h0, 32'h8000_0400, 8'hFF);
        // Interrupts
        add(5'b00001, 5'b00000, 5'd1, 32'h55, 32'h0, 3'b110, 32'h1234_5678, 32'h8000_0100, 8'h10);
        add(5'b10000, 5'b10000, 5'd12, 32'h0, 32'h342, 3'b000, 32'h8000_0010, 32'h0, 8'hFF);
        add(5'b01000, cfu_ecall, 5'd1, 32'h0, 32'h0, 3'b010, 32'h1234_5678, 32'h8000_0100, 8'h0B);
        add(5'b01000, cfu_mret, 5'd0, 32'h0, 32'h0, 3'b000, 32'h0, 32'h8000_0104, 8'hFF);
        add(5'b00001, 5'b00000, 5'd11, 32'hCAFE, 32'h0, 3'b000, 32'hCAFE, 32'h0, 8'hFF);

        repeat (2) @(posedge g_clk);
        #1;
        g_resetn = 1'b1;
        @(negedge g_clk);
        check_value("trs_valid", 32'(trs_valid), 32'h0, -1);
        check_value("cf_req", 32'(cf_req), 32'h0, -1);
        @(posedge g_clk);
        #1;

        for (int i = 0; i < tbl.size(); i++) begin
            run_entry(i);
            if (timed_out) break;
        end

        $display("Run complete: %0d errors, %0d entries, timeout %0d",
                 errors, tbl.size(), timed_out);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- frv_wb_top.f
hw/frv_wb_pkg.sv
hw/frv_load_align.sv
hw/frv_gpr_file.sv
hw/frv_csr_regs.sv
hw/frv_pipeline_writeback.sv
hw/frv_wb_top.sv
tests/tb_frv_wb_top.sv

//--- Makefile
TOP = tb_frv_wb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f frv_wb_top.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -f frv_wb_top.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
